/* tb/ltssm_cases.txt */
# name  lanes_detected  answering_lanes  partner_link  outcome  link_width
# masks are binary with lane 3 on the left, link is hex and 00 echoes ours
no_answer       1111 0000 00 error   0000
all_four        1111 1111 00 success 1111
lanes_01        0011 0011 00 success 0011
lanes_012       0111 0111 00 success 0011
lanes_02        0101 0101 00 success 0001
lanes_013       1011 1011 00 success 0011
single_lane     0001 0001 00 success 0001
wrong_link      1111 1111 3c error   0000
all_four_again  1111 1111 00 success 1111
lanes_12        0110 0110 00 error   0000
wrong_link_01   0011 0011 7e error   0000
retrain_01      0011 0011 00 success 0011

/* build.f */
hw/pcie_phy_pkg.sv
hw/ts_rx_qualifier.sv
hw/ltssm_polling.sv
hw/ltssm_configuration.sv
hw/os_tx_arbiter.sv
hw/os_tx_framer.sv
hw/ltssm_top.sv
tb/ltssm_props.sv
tb/ltssm_tb.sv

/* Makefile */
# Verilator build and run of the LTSSM slice testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run ltssm_tb, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -f build.f \
		--top-module ltssm_tb -o ltssm_sim
	-./obj_dir/ltssm_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb/ltssm_tb.sv */
// ----------------------------------------------------------
// testbench for the LTSSM slice: echoing link partner,
// case file driven outcomes and transmit frame checks
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ltssm_tb
  import pcie_phy_pkg::*;
();

  logic                       clk;
  logic                       rst;
  logic                       start;
  logic    [NUM_LANES-1:0]    lanes_detected;
  rx_os_t  [NUM_LANES-1:0]    rx_os;
  tx_sym_t [NUM_LANES-1:0]    tx;
  logic    [NUM_LANES-1:0]    link_width;
  logic                       link_up;
  logic                       success;
  logic                       error;

  // partner model and frame monitor state
  integer                            seed;
  int                                errors;
  int                                num_cases;
  reg      [8*16-1:0]                test_name;
  logic    [NUM_LANES-1:0]           answer_mask;
  logic    [7:0]                     partner_link;
  logic    [NUM_LANES-1:0][3:0][7:0] sym_buf;
  logic    [NUM_LANES-1:0]           exp_link;
  int                                sym_idx;
  logic                              numbered;
  rx_os_t  [NUM_LANES-1:0]           pend_os;
  logic                              pend_valid;
  int                                pend_delay;

  ltssm_top i_dut (
    .clk_i            (clk),
    .rst_i            (rst),
    .start_i          (start),
    .lanes_detected_i (lanes_detected),
    .rx_os_i          (rx_os),
    .tx_o             (tx),
    .link_width_o     (link_width),
    .link_up_o        (link_up),
    .success_o        (success),
    .error_o          (error)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("** Error %0s %0s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  function automatic os_kind_e kind_of_code(input logic [7:0] code);
    if (code == TS1_ID) begin
      return OS_TS1;
    end else if (code == TS2_ID) begin
      return OS_TS2;
    end else if (code == IDLE_ID) begin
      return OS_IDLE;
    end
    return OS_NONE;
  endfunction

  // ----------------------------------------------------------
  // one complete set seen on tx is checked and echoed
  // ----------------------------------------------------------
  task automatic finish_set();
    os_kind_e   kind;
    logic [7:0] link;
    if (exp_link != '0 && sym_buf[0][2] == 8'h00) begin
      numbered = 1'b1;
    end
    pend_os = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      kind = kind_of_code(sym_buf[l][0]);
      if (kind == OS_NONE) begin
        errors++;
        $display("%0s: lane %0d sent unknown kind code %0h", test_name, l, sym_buf[l][0]);
      end
      check_value("rate symbol", 32'(RATE_ID), 32'(sym_buf[l][3]));
      // a silent partner leaves only Polling sending
      if (answer_mask == '0) begin
        check_value("polling kind", 32'(TS1_ID), 32'(sym_buf[l][0]));
        check_value("polling link", 32'(PAD_SYM), 32'(sym_buf[l][1]));
        check_value("polling lane", 32'(PAD_SYM), 32'(sym_buf[l][2]));
      end
      if (numbered) begin
        check_value("lane number", exp_link[l] ? 32'(l) : 32'(PAD_SYM),
                    32'(sym_buf[l][2]));
      end
      if (answer_mask[l]) begin
        link = sym_buf[l][1];
        if (partner_link != 8'h00 && link != PAD_SYM) begin
          link = partner_link;
        end
        pend_os[l].valid    = 1'b1;
        pend_os[l].kind     = kind;
        pend_os[l].link_num = link;
        pend_os[l].lane_num = sym_buf[l][2];
      end
    end
    pend_valid = 1'b1;
    pend_delay = $random(seed) & 3;
  endtask

  task automatic partner_step();
    rx_os = '0;
    if (pend_valid) begin
      if (pend_delay == 0) begin
        rx_os      = pend_os;
        pend_valid = 1'b0;
      end else begin
        pend_delay--;
      end
    end
    // stray TS1s on silent lanes with foreign link numbers
    for (int l = 0; l < NUM_LANES; l++) begin
      if (!answer_mask[l] && ($random(seed) & 31) == 0) begin
        rx_os[l].valid    = 1'b1;
        rx_os[l].kind     = OS_TS1;
        rx_os[l].link_num = 8'hA0 | 8'($random(seed) & 15);
        rx_os[l].lane_num = 8'($random(seed));
      end
    end
    // every lane frames the same symbol slots
    for (int l = 1; l < NUM_LANES; l++) begin
      check_value("lane valid", 32'(tx[0].valid), 32'(tx[l].valid));
      check_value("lane first", 32'(tx[0].first), 32'(tx[l].first));
    end
    if (tx[0].valid) begin
      sym_idx = tx[0].first ? 0 : sym_idx + 1;
      if (sym_idx > 3) begin
        errors++;
        $display("%0s: tx valid ran past four symbols", test_name);
      end else begin
        for (int l = 0; l < NUM_LANES; l++) begin
          sym_buf[l][sym_idx] = tx[l].sym;
        end
        if (sym_idx == 3) begin
          finish_set();
        end
      end
    end
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    partner_step();
  endtask

  task automatic run_case(input logic [3:0] det, input logic [3:0] ans,
                          input logic [7:0] link, input logic exp_ok,
                          input logic [3:0] exp_width);
    int   limit;
    int   waited;
    logic got_ok;
    logic got_err;
    lanes_detected = det;
    answer_mask    = ans;
    partner_link   = link;
    exp_link       = exp_width;
    numbered       = 1'b0;
    pend_valid     = 1'b0;
    got_ok         = 1'b0;
    got_err        = 1'b0;
    waited         = 0;
    // a silent partner leaves only the Polling timeout
    limit = (ans == '0) ? int'(POLL_TIMEOUT) + 20 : int'(POLL_TIMEOUT + CFG_TIMEOUT) + 20;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    while (!got_ok && !got_err && waited < limit) begin
      next_cycle();
      waited++;
      got_ok  = success;
      got_err = error;
    end
    if (!got_ok && !got_err) begin
      errors++;
      $display("%0s: no success or error strobe within %0d cycles", test_name, limit);
    end else begin
      check_value("success strobe", 32'(exp_ok), 32'(got_ok));
      check_value("error strobe", 32'(!exp_ok), 32'(got_err));
      check_value("link width", 32'(exp_width), 32'(link_width));
      if (exp_ok) begin
        check_value("lane numbering seen", 32'(1), 32'(numbered));
      end
      next_cycle();
      check_value("link up", 32'(exp_ok), 32'(link_up));
    end
    // drain the last set and its echo
    repeat (12) next_cycle();
    check_value("link width held", 32'(exp_width), 32'(link_width));
    check_value("link up held", 32'(exp_ok), 32'(link_up));
  endtask

  initial begin
    integer          fd;
    int              n;
    reg [8*96-1:0]   line;
    reg [8*16-1:0]   name;
    reg [8*8-1:0]    outcome;
    logic [3:0]      det;
    logic [3:0]      ans;
    logic [7:0]      link;
    logic [3:0]      width;
    clk            = 1'b0;
    rst            = 1'b1;
    start          = 1'b0;
    lanes_detected = '0;
    rx_os          = '0;
    seed           = 16728;
    errors         = 0;
    num_cases      = 0;
    test_name      = '0;
    answer_mask    = '0;
    partner_link   = '0;
    sym_buf        = '0;
    exp_link       = '0;
    sym_idx        = 0;
    numbered       = 1'b0;
    pend_os        = '0;
    pend_valid     = 1'b0;
    pend_delay     = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fd = $fopen("tb/ltssm_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file tb/ltssm_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        // comment and blank lines never scan all six fields
        n = $sscanf(line, "%s %b %b %h %s %b", name, det, ans, link, outcome, width);
        if (n == 6) begin
          test_name = name;
          num_cases++;
          run_case(det, ans, link, outcome == 64'("success"), width);
        end
      end
      $fclose(fd);
    end
    $display("%0d cases run, %0d errors", num_cases, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/ltssm_props.sv */
// ----------------------------------------------------------
// bound checks on tx framing, grants and outcome strobes
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ltssm_props
  import pcie_phy_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire tx_sym_t [NUM_LANES-1:0]    tx_i,
  input  wire logic    [1:0]              grant_i,
  input  wire logic                       success_i,
  input  wire logic                       error_i,
  input  wire logic                       link_up_i
);

  logic valid_c;
  logic first_c;

  assign valid_c = tx_i[0].valid;
  assign first_c = tx_i[0].first;

  // a set is four valid symbols with first only on the opening one
  a_set_body: assert property (@(posedge clk_i) disable iff (rst_i)
    ($past(first_c) || $past(first_c, 2) || $past(first_c, 3)) |-> (valid_c && !first_c))
    else $error("ordered set shorter than four symbols");

  a_set_length: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_c && !first_c) |-> ($past(first_c) || $past(first_c, 2) || $past(first_c, 3)))
    else $error("ordered set longer than four symbols");

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(grant_i))
    else $error("more than one grant");

  // symbol 0 goes out the cycle after a grant
  a_grant_start: assert property (@(posedge clk_i) disable iff (rst_i)
    (|grant_i) |=> first_c)
    else $error("grant not followed by symbol 0");

  a_outcome_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(success_i && error_i))
    else $error("success and error together");

  a_link_down: assert property (@(posedge clk_i) disable iff (rst_i)
    error_i |-> !link_up_i)
    else $error("link up during error");

endmodule

bind ltssm_top ltssm_props i_props (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .tx_i      (tx_o),
  .grant_i   (grant),
  .success_i (success_o),
  .error_i   (error_o),
  .link_up_i (link_up_o)
);

`default_nettype wire

/* hw/ltssm_top.sv */
// ----------------------------------------------------------
// LTSSM slice top: receive qualifier, Polling and
// Configuration machines, shared ordered-set transmit path
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ltssm_top
  import pcie_phy_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       start_i,
  input  wire logic    [NUM_LANES-1:0]    lanes_detected_i,
  input  wire rx_os_t  [NUM_LANES-1:0]    rx_os_i,
  output      tx_sym_t [NUM_LANES-1:0]    tx_o,
  output      logic    [NUM_LANES-1:0]    link_width_o,
  output      logic                       link_up_o,
  output      logic                       success_o,
  output      logic                       error_o
);

  lane_run_t [NUM_LANES-1:0] lane_run;
  // index 0 polling, index 1 configuration
  logic      [1:0]           req;
  logic      [1:0]           grant;
  os_req_t   [1:0]           os_req;
  os_req_t                   fr_req;
  logic                      fr_start;
  logic                      fr_busy;
  logic                      poll_done;
  logic                      poll_error;
  logic                      cfg_success;
  logic                      cfg_error;
  logic                      link_up_q;

  ts_rx_qualifier i_qualifier (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rx_os_i    (rx_os_i),
    .lane_run_o (lane_run)
  );

  ltssm_polling i_polling (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .start_i          (start_i),
    .lanes_detected_i (lanes_detected_i),
    .lane_run_i       (lane_run),
    .grant_i          (grant[0]),
    .req_o            (req[0]),
    .os_req_o         (os_req[0]),
    .poll_done_o      (poll_done),
    .poll_error_o     (poll_error)
  );

  ltssm_configuration i_config (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .poll_done_i      (poll_done),
    .lanes_detected_i (lanes_detected_i),
    .lane_run_i       (lane_run),
    .grant_i          (grant[1]),
    .req_o            (req[1]),
    .os_req_o         (os_req[1]),
    .link_width_o     (link_width_o),
    .success_o        (cfg_success),
    .error_o          (cfg_error)
  );

  os_tx_arbiter i_arbiter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req),
    .os_req_i (os_req),
    .busy_i   (fr_busy),
    .grant_o  (grant),
    .start_o  (fr_start),
    .os_req_o (fr_req)
  );

  os_tx_framer i_framer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (fr_start),
    .os_req_i     (fr_req),
    .link_width_i (link_width_o),
    .busy_o       (fr_busy),
    .tx_o         (tx_o)
  );

  // link stays up from success until a retrain or an error
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      link_up_q <= 1'b0;
    end else if (start_i || poll_error || cfg_error) begin
      link_up_q <= 1'b0;
    end else if (cfg_success) begin
      link_up_q <= 1'b1;
    end
  end

  assign link_up_o = link_up_q;
  assign success_o = cfg_success;
  assign error_o   = poll_error | cfg_error;

endmodule

`default_nettype wire

/* hw/os_tx_framer.sv */
// ----------------------------------------------------------
// ordered-set framer: four symbols per lane for each start,
// with per-lane lane numbering
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module os_tx_framer
  import pcie_phy_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       start_i,
  input  wire os_req_t                    os_req_i,
  input  wire logic    [NUM_LANES-1:0]    link_width_i,
  output      logic                       busy_o,
  output      tx_sym_t [NUM_LANES-1:0]    tx_o
);

  logic          active_q;
  logic [1:0]    cnt_q;
  os_req_t       req_q;

  function automatic logic [7:0] kind_code(os_kind_e kind);
    unique case (kind)
      OS_TS1:  return TS1_ID;
      OS_TS2:  return TS2_ID;
      OS_IDLE: return IDLE_ID;
      default: return PAD_SYM;
    endcase
  endfunction

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      cnt_q <= cnt_q + 2'd1;
      if (cnt_q == 2'(OS_SYMBOLS - 1)) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      req_q <= os_req_i;
    end
  end

  // frees up one cycle early so a grant lands on the last symbol
  assign busy_o = start_i || (active_q && cnt_q < 2'(OS_SYMBOLS - 2));

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      tx_o[l].valid = active_q;
      tx_o[l].first = active_q && cnt_q == 2'd0;
      tx_o[l].spare = 1'b0;
      unique case (cnt_q)
        2'd0: tx_o[l].sym = kind_code(req_q.kind);
        2'd1: tx_o[l].sym = req_q.link_num;
        2'd2: tx_o[l].sym = (req_q.lane_assign && link_width_i[l]) ? 8'(l) : PAD_SYM;
        default: tx_o[l].sym = RATE_ID;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/os_tx_arbiter.sv */
// ----------------------------------------------------------
// round-robin arbiter for the ordered-set framer
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module os_tx_arbiter
  import pcie_phy_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire logic    [1:0]        req_i,
  input  wire os_req_t [1:0]        os_req_i,
  input  wire logic                 busy_i,
  output      logic    [1:0]        grant_o,
  output      logic                 start_o,
  output      os_req_t              os_req_o
);

  logic    [1:0] grant_q;
  logic    [1:0] grant_d;
  logic          last_q;
  os_req_t       os_req_q;

  // on a tie the requester that did not win last time goes
  always_comb begin
    grant_d = 2'b00;
    if (!busy_i) begin
      if (req_i == 2'b11) begin
        grant_d = last_q ? 2'b01 : 2'b10;
      end else begin
        grant_d = req_i;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      grant_q <= 2'b00;
      last_q  <= 1'b0;
    end else begin
      grant_q <= grant_d;
      if (|grant_d) begin
        last_q <= grant_d[1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|grant_d) begin
      os_req_q <= grant_d[1] ? os_req_i[1] : os_req_i[0];
    end
  end

  assign grant_o  = grant_q;
  assign start_o  = |grant_q;
  assign os_req_o = os_req_q;

endmodule

`default_nettype wire

/* hw/ltssm_configuration.sv */
// ----------------------------------------------------------
// Configuration state machine, downstream port: agrees on
// link width and lane numbers, then trains to idle
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ltssm_configuration
  import pcie_phy_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         poll_done_i,
  input  wire logic      [NUM_LANES-1:0]    lanes_detected_i,
  input  wire lane_run_t [NUM_LANES-1:0]    lane_run_i,
  input  wire logic                         grant_i,
  output      logic                         req_o,
  output      os_req_t                      os_req_o,
  output      logic      [NUM_LANES-1:0]    link_width_o,
  output      logic                         success_o,
  output      logic                         error_o
);

  typedef enum logic [2:0] {
    ST_OFF,
    ST_LW_START,
    ST_LW_ACCEPT,
    ST_LN_WAIT,
    ST_LN_ACCEPT,
    ST_COMPLETE,
    ST_CFG_IDLE
  } cfg_state_e;

  cfg_state_e                   state_q;
  cfg_state_e                   state_d;
  logic      [23:0]             timer_q;
  logic      [3:0]              sent_q;
  logic      [NUM_LANES-1:0]    width_q;
  logic      [NUM_LANES-1:0]    width_d;
  logic      [NUM_LANES-1:0]    form_c;
  logic                         success_q;
  logic                         success_d;
  logic                         error_q;
  logic                         error_d;
  logic                         snap_en_c;
  lane_run_t [NUM_LANES-1:0]    snap_q;
  logic      [NUM_LANES-1:0][3:0] run_c;
  logic      [NUM_LANES-1:0]    lw_echo_c;
  logic      [NUM_LANES-1:0]    ln_match_c;
  logic      [NUM_LANES-1:0]    ln_ok_c;
  logic      [NUM_LANES-1:0]    ts2_ok_c;
  logic      [NUM_LANES-1:0]    idle_ok_c;

  // ----------------------------------------------------------
  // per-lane echo checks against the entry snapshot
  // ----------------------------------------------------------
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      run_c[l]      = run_since(lane_run_i[l], snap_q[l]);
      lw_echo_c[l]  = lanes_detected_i[l] && lane_run_i[l].kind == OS_TS1 &&
                      lane_run_i[l].link_num == LINK_NUM &&
                      lane_run_i[l].lane_num == PAD_SYM && run_c[l] >= TS1_RUN_CFG;
      ln_match_c[l] = lane_run_i[l].link_num == LINK_NUM &&
                      lane_run_i[l].lane_num == 8'(l) && run_c[l] != 4'd0;
      ln_ok_c[l]    = ln_match_c[l] && lane_run_i[l].kind == OS_TS1 &&
                      run_c[l] >= TS1_RUN_CFG;
      ts2_ok_c[l]   = ln_match_c[l] && lane_run_i[l].kind == OS_TS2 &&
                      run_c[l] >= TS2_RUN_CFG;
      idle_ok_c[l]  = lane_run_i[l].kind == OS_IDLE && run_c[l] >= IDLE_RUN_CFG;
    end
  end

  // largest contiguous power-of-two group from lane 0
  always_comb begin
    if (&lw_echo_c) begin
      form_c = 4'b1111;
    end else if (lw_echo_c[1:0] == 2'b11) begin
      form_c = 4'b0011;
    end else if (lw_echo_c[0]) begin
      form_c = 4'b0001;
    end else begin
      form_c = 4'b0000;
    end
  end

  always_comb begin
    state_d   = state_q;
    width_d   = width_q;
    success_d = 1'b0;
    error_d   = 1'b0;
    unique case (state_q)
      ST_OFF: begin
        if (poll_done_i) begin
          state_d = ST_LW_START;
          width_d = '0;
        end
      end
      ST_LW_START: if (lw_echo_c[0]) state_d = ST_LW_ACCEPT;
      ST_LW_ACCEPT: begin
        // let the slower lanes catch up for two more sets
        if (sent_q >= TS1_RUN_CFG) begin
          width_d = form_c;
          state_d = form_c[0] ? ST_LN_WAIT : ST_LW_START;
        end
      end
      ST_LN_WAIT: if (ln_match_c[0]) state_d = ST_LN_ACCEPT;
      ST_LN_ACCEPT: if ((ln_ok_c & width_q) == width_q) state_d = ST_COMPLETE;
      ST_COMPLETE: begin
        if ((ts2_ok_c & width_q) == width_q && sent_q >= TS2_RUN_CFG) begin
          state_d = ST_CFG_IDLE;
        end
      end
      default: begin
        if ((idle_ok_c & width_q) == width_q && sent_q >= IDLE_RUN_CFG) begin
          state_d   = ST_OFF;
          success_d = 1'b1;
        end
      end
    endcase
    // one timer over all substates
    if (state_q != ST_OFF && timer_q == CFG_TIMEOUT - 24'd1) begin
      state_d   = ST_OFF;
      width_d   = '0;
      success_d = 1'b0;
      error_d   = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= ST_OFF;
      timer_q   <= '0;
      sent_q    <= '0;
      width_q   <= '0;
      success_q <= 1'b0;
      error_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      width_q   <= width_d;
      success_q <= success_d;
      error_q   <= error_d;
      timer_q   <= (state_q == ST_OFF) ? 24'd0 : timer_q + 24'd1;
      if (state_d != state_q) begin
        sent_q <= '0;
      end else if (grant_i && sent_q != RUN_MAX) begin
        sent_q <= sent_q + 4'd1;
      end
    end
  end

  // fresh baseline whenever a new kind of echo is awaited
  assign snap_en_c = (state_d != state_q) &&
                     (state_d == ST_LW_START || state_d == ST_LN_WAIT ||
                      state_d == ST_COMPLETE || state_d == ST_CFG_IDLE);

  always_ff @(posedge clk_i) begin
    if (snap_en_c) begin
      snap_q <= lane_run_i;
    end
  end

  always_comb begin
    unique case (state_q)
      ST_OFF:       os_req_o = '{kind: OS_NONE, link_num: PAD_SYM, lane_assign: 1'b0};
      ST_LW_START,
      ST_LW_ACCEPT: os_req_o = '{kind: OS_TS1, link_num: LINK_NUM, lane_assign: 1'b0};
      ST_LN_WAIT,
      ST_LN_ACCEPT: os_req_o = '{kind: OS_TS1, link_num: LINK_NUM, lane_assign: 1'b1};
      ST_COMPLETE:  os_req_o = '{kind: OS_TS2, link_num: LINK_NUM, lane_assign: 1'b1};
      default:      os_req_o = '{kind: OS_IDLE, link_num: LINK_NUM, lane_assign: 1'b1};
    endcase
  end

  assign req_o        = (state_q != ST_OFF);
  assign link_width_o = width_q;
  assign success_o    = success_q;
  assign error_o      = error_q;

endmodule

`default_nettype wire

/* hw/ltssm_polling.sv */
// ----------------------------------------------------------
// Polling state machine: sends PAD TS1s until every detected
// lane answers with a PAD training set run
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ltssm_polling
  import pcie_phy_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         start_i,
  input  wire logic      [NUM_LANES-1:0]    lanes_detected_i,
  input  wire lane_run_t [NUM_LANES-1:0]    lane_run_i,
  input  wire logic                         grant_i,
  output      logic                         req_o,
  output      os_req_t                      os_req_o,
  output      logic                         poll_done_o,
  output      logic                         poll_error_o
);

  typedef enum logic {
    P_OFF,
    P_ACTIVE
  } poll_state_e;

  poll_state_e               state_q;
  logic      [23:0]          timer_q;
  logic      [3:0]           sent_q;
  logic                      done_q;
  logic                      error_q;
  lane_run_t [NUM_LANES-1:0] snap_q;
  logic      [NUM_LANES-1:0] pad_ok_c;
  logic                      all_ok_c;

  // partner answers with TS1 or TS2 and PAD link and lane
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      pad_ok_c[l] = (lane_run_i[l].kind == OS_TS1 || lane_run_i[l].kind == OS_TS2) &&
                    lane_run_i[l].link_num == PAD_SYM &&
                    lane_run_i[l].lane_num == PAD_SYM &&
                    run_since(lane_run_i[l], snap_q[l]) >= TS1_RUN_POLL;
    end
    all_ok_c = (|lanes_detected_i) &&
               ((pad_ok_c & lanes_detected_i) == lanes_detected_i) &&
               sent_q >= TS1_RUN_POLL;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= P_OFF;
      timer_q <= '0;
      sent_q  <= '0;
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end else begin
      done_q  <= 1'b0;
      error_q <= 1'b0;
      case (state_q)
        P_OFF: begin
          if (start_i) begin
            state_q <= P_ACTIVE;
            timer_q <= '0;
            sent_q  <= '0;
          end
        end
        default: begin
          timer_q <= timer_q + 24'd1;
          if (grant_i && sent_q != RUN_MAX) begin
            sent_q <= sent_q + 4'd1;
          end
          if (all_ok_c) begin
            state_q <= P_OFF;
            done_q  <= 1'b1;
          end else if (timer_q == POLL_TIMEOUT - 24'd1) begin
            state_q <= P_OFF;
            error_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // counts before entry are history from an earlier run
  always_ff @(posedge clk_i) begin
    if (start_i && state_q == P_OFF) begin
      snap_q <= lane_run_i;
    end
  end

  assign req_o        = (state_q == P_ACTIVE);
  assign os_req_o     = '{kind: OS_TS1, link_num: PAD_SYM, lane_assign: 1'b0};
  assign poll_done_o  = done_q;
  assign poll_error_o = error_q;

endmodule

`default_nettype wire

/* hw/ts_rx_qualifier.sv */
// ----------------------------------------------------------
// receive qualifier: per-lane run count of identical
// consecutive ordered sets, saturating
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ts_rx_qualifier
  import pcie_phy_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire rx_os_t    [NUM_LANES-1:0]    rx_os_i,
  output      lane_run_t [NUM_LANES-1:0]    lane_run_o
);

  lane_run_t [NUM_LANES-1:0] run_q;
  logic      [NUM_LANES-1:0] same_c;

  // new set matches the lane's previous one
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      same_c[l] = (rx_os_i[l].kind == run_q[l].kind) &&
                  (rx_os_i[l].link_num == run_q[l].link_num) &&
                  (rx_os_i[l].lane_num == run_q[l].lane_num);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      run_q <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (rx_os_i[l].valid) begin
          if (same_c[l]) begin
            // saturate at RUN_MAX
            if (run_q[l].cnt != RUN_MAX) begin
              run_q[l].cnt <= run_q[l].cnt + 4'd1;
            end
          end else begin
            run_q[l].kind     <= rx_os_i[l].kind;
            run_q[l].link_num <= rx_os_i[l].link_num;
            run_q[l].lane_num <= rx_os_i[l].lane_num;
            run_q[l].cnt      <= 4'd1;
          end
        end
      end
    end
  end

  assign lane_run_o = run_q;

endmodule

`default_nettype wire

/* hw/pcie_phy_pkg.sv */
// ----------------------------------------------------------
// PCIe PHY training package: lane count, ordered-set codes,
// run thresholds, timeouts and the shared link structs
// ----------------------------------------------------------
`default_nettype none

package pcie_phy_pkg;

  localparam int NUM_LANES  = 4;
  localparam int OS_SYMBOLS = 4;

  // ----------------------------------------------------------
  // ordered-set symbol codes
  // ----------------------------------------------------------
  localparam logic [7:0] PAD_SYM  = 8'hF7;
  localparam logic [7:0] TS1_ID   = 8'h4A;
  localparam logic [7:0] TS2_ID   = 8'h45;
  localparam logic [7:0] IDLE_ID  = 8'h7C;
  localparam logic [7:0] LINK_NUM = 8'h05;
  localparam logic [7:0] RATE_ID  = 8'h02;

  // received runs needed per step
  localparam logic [3:0] TS1_RUN_POLL = 4'd8;
  localparam logic [3:0] TS1_RUN_CFG  = 4'd2;
  localparam logic [3:0] TS2_RUN_CFG  = 4'd8;
  localparam logic [3:0] IDLE_RUN_CFG = 4'd8;
  localparam logic [3:0] RUN_MAX      = 4'd15;

  // short values for simulation
  localparam logic [23:0] POLL_TIMEOUT = 24'd3000;
  localparam logic [23:0] CFG_TIMEOUT  = 24'd2000;

  typedef enum logic [1:0] {
    OS_NONE,
    OS_TS1,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  typedef struct packed {
    logic       valid;
    os_kind_e   kind;
    logic [7:0] link_num;
    logic [7:0] lane_num;
  } rx_os_t;

  typedef struct packed {
    os_kind_e   kind;
    logic [7:0] link_num;
    logic [7:0] lane_num;
    logic [3:0] cnt;
  } lane_run_t;

  typedef struct packed {
    os_kind_e   kind;
    logic [7:0] link_num;
    // 1 numbers active lanes by index, 0 sends PAD
    logic       lane_assign;
  } os_req_t;

  typedef struct packed {
    logic       valid;
    logic       first;
    logic [7:0] sym;
    logic       spare;
  } tx_sym_t;

  // run length gathered since a snapshot of the same lane
  function automatic logic [3:0] run_since(lane_run_t cur, lane_run_t snap);
    if (cur.kind == snap.kind && cur.link_num == snap.link_num &&
        cur.lane_num == snap.lane_num && cur.cnt >= snap.cnt) begin
      return cur.cnt - snap.cnt;
    end
    return cur.cnt;
  endfunction

endpackage

`default_nettype wire
